/* source/hps_link_pkg.sv */
// host link package: command codes, widths and the bus, slot and payload types
`default_nettype none

package hps_link_pkg;

	////////////////////////////////////////
	// widths
	localparam int WORD_W  = 16;
	localparam int IDX_W   = 4;
	localparam int ADDR_W  = 27;
	localparam int STFLG_W = 4;

	// ioctl address advance per 16-bit data word
	localparam int ADDR_STEP = 2;

	////////////////////////////////////////
	// command codes, first word of a frame
	localparam logic [WORD_W-1:0] CMD_JOY0       = 16'h0002;
	localparam logic [WORD_W-1:0] CMD_JOY1       = 16'h0003;
	localparam logic [WORD_W-1:0] CMD_KBD        = 16'h0005;
	localparam logic [WORD_W-1:0] CMD_STATUS     = 16'h001E;
	localparam logic [WORD_W-1:0] CMD_STATUS_REQ = 16'h0029;
	localparam logic [WORD_W-1:0] CMD_FILE_TX    = 16'h0053;
	localparam logic [WORD_W-1:0] CMD_FILE_DAT   = 16'h0054;
	localparam logic [WORD_W-1:0] CMD_FILE_INDEX = 16'h0055;

	// status request header, tag sits above the request counter
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	// keyboard byte markers
	localparam logic [7:0] KBD_SKIP    = 8'hFF;
	localparam logic [7:0] KBD_RELEASE = 8'hF0;
	localparam logic [7:0] KBD_EXTEND  = 8'hE0;

	////////////////////////////////////////
	// types
	typedef struct packed {
		logic              enable;
		logic              strobe;
		logic [WORD_W-1:0] din;
	} host_bus_t;

	typedef struct packed {
		logic              strobe;
		logic [IDX_W-1:0]  idx;
		logic [WORD_W-1:0] data;
		logic              sel_joy0;
		logic              sel_joy1;
		logic              sel_status;
		logic              sel_status_req;
		logic              sel_kbd;
		logic              sel_file_tx;
		logic              sel_file_dat;
		logic              sel_file_index;
		logic              frame_end;
	} cmd_slot_t;

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;

	// toggle flips with every event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic [WORD_W-1:0] index;
	} ioctl_t;

endpackage

`default_nettype wire

/* source/word_collector.sv */
// word collector: builds a wide payload from successive 16-bit frame words
`timescale 1ns/1ps
`default_nettype none

module word_collector #(
	parameter type payload_t = hps_link_pkg::joy_t
) (
	input  wire logic                    clk_sys,
	input  wire logic                    rst_n,
	input  wire hps_link_pkg::cmd_slot_t slot,
	input  wire logic                    sel,
	output payload_t                     payload
);

	logic [$bits(payload_t)-1:0]    payload_q;
	logic [hps_link_pkg::IDX_W-1:0] slice;
	logic                           in_range;

	// word 1 lands in the lowest slice
	assign slice = slot.idx - 1'b1;

	// words past the payload width fall through
	assign in_range = (slot.idx != '0) &&
		(int'(slot.idx) <= $bits(payload_t) / hps_link_pkg::WORD_W);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			payload_q <= '0;
		end else if (slot.strobe && sel && in_range) begin
			payload_q[slice * hps_link_pkg::WORD_W +: hps_link_pkg::WORD_W] <= slot.data;
		end
	end

	assign payload = payload_t'(payload_q);

endmodule

`default_nettype wire

/* source/host_cmd_ctrl.sv */
// host command control: frame tracking, word index, command select decode and readback
`timescale 1ns/1ps
`default_nettype none

module host_cmd_ctrl (
	input  wire logic                             clk_sys,
	input  wire logic                             rst_n,
	input  wire hps_link_pkg::host_bus_t          host,
	input  wire logic [hps_link_pkg::WORD_W-1:0]  rd_status,
	output hps_link_pkg::cmd_slot_t               slot,
	output logic [hps_link_pkg::WORD_W-1:0]       dout
);

	logic [hps_link_pkg::WORD_W-1:0] cmd_q;
	logic [hps_link_pkg::IDX_W-1:0]  idx_q;
	logic                            en_q;
	logic                            word_in;
	logic [hps_link_pkg::WORD_W-1:0] code;

	assign word_in = host.enable & host.strobe;

	// word 0 carries the command itself, later words use the latched one
	assign code = (idx_q == '0) ? host.din : cmd_q;

	////////////////////////////////////////
	// frame state
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd_q <= '0;
			idx_q <= '0;
			en_q  <= 1'b0;
		end else begin
			en_q <= host.enable;
			if (!host.enable) begin
				cmd_q <= '0;
				idx_q <= '0;
			end else if (word_in) begin
				if (idx_q == '0) begin
					cmd_q <= host.din;
				end
				// saturate so long frames keep a stable index
				if (idx_q != '1) begin
					idx_q <= idx_q + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// registered slot to the datapath
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			slot <= '0;
		end else begin
			slot.strobe         <= word_in;
			slot.idx            <= idx_q;
			slot.data           <= host.din;
			slot.sel_joy0       <= word_in && (code == hps_link_pkg::CMD_JOY0);
			slot.sel_joy1       <= word_in && (code == hps_link_pkg::CMD_JOY1);
			slot.sel_status     <= word_in && (code == hps_link_pkg::CMD_STATUS);
			slot.sel_status_req <= word_in && (code == hps_link_pkg::CMD_STATUS_REQ);
			slot.sel_kbd        <= word_in && (code == hps_link_pkg::CMD_KBD);
			slot.sel_file_tx    <= word_in && (code == hps_link_pkg::CMD_FILE_TX);
			slot.sel_file_dat   <= word_in && (code == hps_link_pkg::CMD_FILE_DAT);
			slot.sel_file_index <= word_in && (code == hps_link_pkg::CMD_FILE_INDEX);
			slot.frame_end      <= en_q && !host.enable;
		end
	end

	// readback holds until the next word, zero between frames
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dout <= '0;
		end else if (slot.strobe) begin
			dout <= slot.sel_status_req ? rd_status : '0;
		end else if (!host.enable) begin
			dout <= '0;
		end
	end

endmodule

`default_nettype wire

/* source/status_exchange.sv */
// status exchange: host-written core status plus core status requests read back by the host
`timescale 1ns/1ps
`default_nettype none

module status_exchange (
	input  wire logic                            clk_sys,
	input  wire logic                            rst_n,
	input  wire hps_link_pkg::cmd_slot_t         slot,
	input  wire hps_link_pkg::status_t           status_in,
	input  wire logic                            status_set,
	output hps_link_pkg::status_t                status,
	output logic [hps_link_pkg::WORD_W-1:0]      rd_word
);

	logic                             set_s1;
	logic                             set_s2;
	logic                             set_rise;
	logic [hps_link_pkg::STFLG_W-1:0] stflg;
	hps_link_pkg::status_t            status_req;

	// status written by the host, 0x1E frames
	word_collector #(
		.payload_t(hps_link_pkg::status_t)
	) status_wc_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.slot    (slot),
		.sel     (slot.sel_status),
		.payload (status)
	);

	////////////////////////////////////////
	// core side request capture
	assign set_rise = set_s1 & ~set_s2;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			set_s1     <= 1'b0;
			set_s2     <= 1'b0;
			stflg      <= '0;
			status_req <= '0;
		end else begin
			set_s1 <= status_set;
			set_s2 <= set_s1;
			// counter lets the host notice a fresh request
			if (set_rise) begin
				stflg      <= stflg + 1'b1;
				status_req <= status_in;
			end
		end
	end

	// readback word for the current slot
	always_comb begin
		rd_word = '0;
		if (slot.sel_status_req) begin
			case (slot.idx)
				4'd0: rd_word = {{(hps_link_pkg::WORD_W - $bits(hps_link_pkg::STATUS_REQ_TAG)
					- hps_link_pkg::STFLG_W){1'b0}}, hps_link_pkg::STATUS_REQ_TAG, stflg};
				4'd1: rd_word = status_req[15:0];
				4'd2: rd_word = status_req[31:16];
				4'd3: rd_word = status_req[47:32];
				4'd4: rd_word = status_req[63:48];
				default: rd_word = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/ps2_key_decoder.sv */
// keyboard decoder: collects scan code bytes of a frame and emits one key event
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder (
	input  wire logic                    clk_sys,
	input  wire logic                    rst_n,
	input  wire hps_link_pkg::cmd_slot_t slot,
	output hps_link_pkg::ps2_key_t       ps2_key
);

	logic [31:0] raw;
	logic        skip;
	logic        kbd_frame;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_low;

	// released keys carry F0 in byte 1, so the E0 prefix moves up a byte
	assign pressed  = (raw[15:8] != hps_link_pkg::KBD_RELEASE);
	assign extended = pressed ? (raw[15:8] == hps_link_pkg::KBD_EXTEND)
		: (raw[23:16] == hps_link_pkg::KBD_EXTEND);

	// multi-byte sequences that don't fit the plain rule
	always_comb begin
		case (raw)
			32'hE012E07C: key_low = 10'h37C;
			32'h7CE0F012: key_low = 10'h17C;
			32'hF014F077: key_low = 10'h377;
			default: key_low = {pressed, extended, raw[7:0]};
		endcase
	end

	////////////////////////////////////////
	// byte collection and event output
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			raw       <= '0;
			skip      <= 1'b0;
			kbd_frame <= 1'b0;
			ps2_key   <= '0;
		end else begin
			if (slot.strobe && slot.idx == '0) begin
				kbd_frame <= slot.sel_kbd;
				if (slot.sel_kbd) begin
					raw  <= '0;
					skip <= 1'b0;
				end
			end else if (slot.strobe && slot.sel_kbd) begin
				if (slot.data[15:8] == hps_link_pkg::KBD_SKIP) begin
					skip <= 1'b1;
				end else if (!skip) begin
					raw <= {raw[23:0], slot.data[7:0]};
				end
			end

			if (slot.frame_end) begin
				kbd_frame <= 1'b0;
				skip      <= 1'b0;
				if (kbd_frame && !skip) begin
					ps2_key.toggle <= ~ps2_key.toggle;
					{ps2_key.pressed, ps2_key.extended, ps2_key.code} <= key_low;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/file_loader.sv */
// file loader: turns host download frames into ioctl writes with valid/ready flow control
`timescale 1ns/1ps
`default_nettype none

module file_loader (
	input  wire logic                    clk_sys,
	input  wire logic                    rst_n,
	input  wire hps_link_pkg::cmd_slot_t slot,
	input  wire logic                    ioctl_ready,
	output logic                         ioctl_valid,
	output hps_link_pkg::ioctl_t         ioctl,
	output logic                         ioctl_download
);

	// address for the next data word
	logic [hps_link_pkg::ADDR_W-1:0] addr;
	logic                            idx_one;
	logic                            data_word;

	assign idx_one   = (slot.idx == 4'd1);
	assign data_word = slot.strobe && slot.sel_file_dat && (slot.idx != '0) && ioctl_download;

	////////////////////////////////////////
	// index and transfer control
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl.index    <= '0;
			addr           <= '0;
		end else if (slot.strobe) begin
			if (slot.sel_file_index && idx_one) begin
				ioctl.index <= slot.data;
			end

			if (slot.sel_file_tx) begin
				case (slot.idx)
					4'd1: begin
						if (slot.data[7:0] != 8'h00) begin
							ioctl_download <= 1'b1;
							addr           <= '0;
						end else if (slot.data == '0) begin
							ioctl_download <= 1'b0;
						end
					end
					4'd2: addr[15:0] <= slot.data;
					4'd3: addr[hps_link_pkg::ADDR_W-1:16] <=
						slot.data[hps_link_pkg::ADDR_W-17:0];
					default: ;
				endcase
			end

			if (data_word) begin
				addr <= addr + hps_link_pkg::ADDR_W'(hps_link_pkg::ADDR_STEP);
			end
		end
	end

	////////////////////////////////////////
	// write handshake
	// payload stays put until the consumer takes it
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_valid <= 1'b0;
			ioctl.addr  <= '0;
			ioctl.data  <= '0;
		end else if (data_word) begin
			ioctl_valid <= 1'b1;
			ioctl.addr  <= addr;
			ioctl.data  <= slot.data;
		end else if (ioctl_valid && ioctl_ready) begin
			ioctl_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/hps_link_top.sv */
// host link top: joystick, status, keyboard and download register block on one host bus
`timescale 1ns/1ps
`default_nettype none

module hps_link_top (
	input  wire logic                            clk_sys,
	input  wire logic                            rst_n,

	// host side
	input  wire hps_link_pkg::host_bus_t         host,
	output logic [hps_link_pkg::WORD_W-1:0]      dout,
	output logic                                 host_wait,

	// core side
	output hps_link_pkg::joy_t                   joystick_0,
	output hps_link_pkg::joy_t                   joystick_1,
	input  wire hps_link_pkg::status_t           status_in,
	input  wire logic                            status_set,
	output hps_link_pkg::status_t                status,
	output hps_link_pkg::ps2_key_t               ps2_key,

	// download stream
	input  wire logic                            ioctl_ready,
	output logic                                 ioctl_valid,
	output hps_link_pkg::ioctl_t                 ioctl,
	output logic                                 ioctl_download
);

	hps_link_pkg::cmd_slot_t         slot;
	logic [hps_link_pkg::WORD_W-1:0] rd_word;

	// host must hold off data words while a write is stalled
	assign host_wait = ioctl_valid & ~ioctl_ready;

	host_cmd_ctrl host_cmd_ctrl_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.host      (host),
		.rd_status (rd_word),
		.slot      (slot),
		.dout      (dout)
	);

	////////////////////////////////////////
	// datapath
	word_collector #(
		.payload_t(hps_link_pkg::joy_t)
	) joy0_wc_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.slot    (slot),
		.sel     (slot.sel_joy0),
		.payload (joystick_0)
	);

	word_collector #(
		.payload_t(hps_link_pkg::joy_t)
	) joy1_wc_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.slot    (slot),
		.sel     (slot.sel_joy1),
		.payload (joystick_1)
	);

	status_exchange status_exchange_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.slot       (slot),
		.status_in  (status_in),
		.status_set (status_set),
		.status     (status),
		.rd_word    (rd_word)
	);

	ps2_key_decoder ps2_key_decoder_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.slot    (slot),
		.ps2_key (ps2_key)
	);

	file_loader file_loader_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.slot           (slot),
		.ioctl_ready    (ioctl_ready),
		.ioctl_valid    (ioctl_valid),
		.ioctl          (ioctl),
		.ioctl_download (ioctl_download)
	);

endmodule

`default_nettype wire

/* include/hps_link_tb_tasks.svh */
// host link testbench tasks: host frame driving, directed tests and compare tasks
`ifndef HPS_LINK_TB_TASKS_SVH
`define HPS_LINK_TB_TASKS_SVH

////////////////////////////////////////
// compare tasks
task automatic check_word(input string name, input logic [hps_link_pkg::WORD_W-1:0] got,
		input logic [hps_link_pkg::WORD_W-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_joy(input string name, input hps_link_pkg::joy_t got,
		input hps_link_pkg::joy_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_status(input string name, input hps_link_pkg::status_t got,
		input hps_link_pkg::status_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_key(input string name, input hps_link_pkg::ps2_key_t got,
		input hps_link_pkg::ps2_key_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_ioctl(input string name, input hps_link_pkg::ioctl_t got,
		input hps_link_pkg::ioctl_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic note_failure(input string what);
	checks++;
	errors++;
	$display("error at %0t: %s", $time, what);
endtask

////////////////////////////////////////
// host frame driving
task automatic frame_open();
	@(posedge clk_sys);
	host.enable <= 1'b1;
endtask

// returns on the edge that drops the strobe
task automatic send_word(input logic [hps_link_pkg::WORD_W-1:0] w);
	@(posedge clk_sys);
	host.strobe <= 1'b1;
	host.din    <= w;
	@(posedge clk_sys);
	host.strobe <= 1'b0;
endtask

// frame_end and the key event need two edges after enable falls
task automatic frame_close();
	@(posedge clk_sys);
	host.enable <= 1'b0;
	repeat (3) @(posedge clk_sys);
	@(negedge clk_sys);
endtask

task automatic short_frame(input logic [15:0] cmd, input logic [15:0] w1);
	frame_open();
	send_word(cmd);
	send_word(w1);
	frame_close();
endtask

// dout is registered one edge after the slot
task automatic read_word(input logic [15:0] w, input logic [15:0] exp);
	send_word(w);
	@(posedge clk_sys);
	@(negedge clk_sys);
	check_word("dout", dout, exp);
endtask

// one data word, then hold off until its write has been taken
task automatic send_data_word(input logic [15:0] w, input hps_link_pkg::ioctl_t exp);
	send_word(w);
	@(posedge clk_sys);
	ioctl_ready <= 1'($random(seed));
	@(negedge clk_sys);
	if (!ioctl_valid) begin
		note_failure("no ioctl write issued for a data word");
	end else begin
		while (host_wait) begin
			@(posedge clk_sys);
			ioctl_ready <= 1'($random(seed));
			@(negedge clk_sys);
		end
		check_ioctl("ioctl", ioctl, exp);
		@(posedge clk_sys);
		ioctl_ready <= 1'($random(seed));
		@(negedge clk_sys);
		if (ioctl_valid) begin
			note_failure("ioctl write still pending after it was accepted");
		end
	end
endtask

task automatic key_frame(input logic [31:0] seq, input int n, input logic pressed,
		input logic extended, input logic [7:0] code);
	int i;
	frame_open();
	send_word(hps_link_pkg::CMD_KBD);
	// oldest byte first, so it ends up in the top of the raw word
	for (i = n - 1; i >= 0; i--) begin
		send_word({8'h00, seq[i*8 +: 8]});
	end
	frame_close();
	key_exp.toggle   = ~key_exp.toggle;
	key_exp.pressed  = pressed;
	key_exp.extended = extended;
	key_exp.code     = code;
	check_key("ps2_key", ps2_key, key_exp);
endtask

////////////////////////////////////////
// directed tests
task automatic joystick_frames();
	logic [15:0] lo;
	logic [15:0] hi;
	int r;
	for (r = 0; r < 3; r++) begin
		lo = 16'($random(seed));
		hi = 16'($random(seed));
		frame_open();
		send_word(hps_link_pkg::CMD_JOY0);
		send_word(lo);
		send_word(hi);
		frame_close();
		joy0_exp = {hi, lo};
		check_joy("joystick_0", joystick_0, joy0_exp);
		check_joy("joystick_1", joystick_1, joy1_exp);

		lo = 16'($random(seed));
		hi = 16'($random(seed));
		frame_open();
		send_word(hps_link_pkg::CMD_JOY1);
		send_word(lo);
		send_word(hi);
		frame_close();
		joy1_exp = {hi, lo};
		check_joy("joystick_1", joystick_1, joy1_exp);
		check_joy("joystick_0", joystick_0, joy0_exp);
	end
endtask

task automatic status_write();
	logic [15:0] w [5];
	int i;
	frame_open();
	send_word(hps_link_pkg::CMD_STATUS);
	// the fifth word lies past the 64-bit payload
	for (i = 0; i < 5; i++) begin
		w[i] = 16'($random(seed));
		send_word(w[i]);
	end
	frame_close();
	check_status("status", status, {w[3], w[2], w[1], w[0]});
endtask

task automatic status_request();
	hps_link_pkg::status_t req;
	int k;
	for (k = 0; k < 2; k++) begin
		req = {$random(seed), $random(seed)};
		@(posedge clk_sys);
		status_in  <= req;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		repeat (4) @(posedge clk_sys);
	end
	// two requests so far, header reads tag A over count 2
	frame_open();
	read_word(hps_link_pkg::CMD_STATUS_REQ, 16'h00A2);
	read_word(16'h0000, req[15:0]);
	read_word(16'h0000, req[31:16]);
	read_word(16'h0000, req[47:32]);
	read_word(16'h0000, req[63:48]);
	frame_close();
	check_word("dout", dout, 16'h0000);
endtask

task automatic keyboard_events();
	key_frame(32'h0000001C, 1, 1'b1, 1'b0, 8'h1C);
	key_frame(32'h0000F01C, 2, 1'b0, 1'b0, 8'h1C);
	key_frame(32'h0000E075, 2, 1'b1, 1'b1, 8'h75);
	key_frame(32'h00E0F075, 3, 1'b0, 1'b1, 8'h75);
	// print screen down, print screen up, pause
	key_frame(32'hE012E07C, 4, 1'b1, 1'b1, 8'h7C);
	key_frame(32'h7CE0F012, 4, 1'b0, 1'b1, 8'h7C);
	key_frame(32'hF014F077, 4, 1'b1, 1'b1, 8'h77);

	// skipped frame leaves the last event and its toggle alone
	frame_open();
	send_word(hps_link_pkg::CMD_KBD);
	send_word(16'hFF00);
	send_word(16'h001C);
	frame_close();
	check_key("ps2_key", ps2_key, key_exp);
endtask

task automatic file_download();
	logic [15:0]          index;
	logic [15:0]          w;
	hps_link_pkg::ioctl_t exp;
	int i;
	index = 16'($random(seed));
	short_frame(hps_link_pkg::CMD_FILE_INDEX, index);

	// start first, then the address words of the same frame
	frame_open();
	send_word(hps_link_pkg::CMD_FILE_TX);
	send_word(16'h0001);
	send_word(16'h0100);
	send_word(16'h0000);
	frame_close();
	if (ioctl_download !== 1'b1) begin
		note_failure("download did not start");
	end

	frame_open();
	send_word(hps_link_pkg::CMD_FILE_DAT);
	for (i = 0; i < 8; i++) begin
		w         = 16'($random(seed));
		exp.addr  = hps_link_pkg::ADDR_W'(32'h100 + i * hps_link_pkg::ADDR_STEP);
		exp.data  = w;
		exp.index = index;
		send_data_word(w, exp);
	end
	frame_close();
	@(posedge clk_sys);
	ioctl_ready <= 1'b1;

	short_frame(hps_link_pkg::CMD_FILE_TX, 16'h0000);
	if (ioctl_download !== 1'b0) begin
		note_failure("download still active after the stop frame");
	end
	if (ioctl_valid !== 1'b0) begin
		note_failure("ioctl write left pending after the transfer");
	end
endtask

`endif

/* tb/hps_link_tb.sv */
// host link testbench: clock, reset, DUT, run timeout and closing report
`timescale 1ns/1ps
`default_nettype none

module hps_link_tb;

	// a few hundred cycles of directed tests plus room for random ready stalls
	localparam int MAX_CYCLES = 4000;

	logic                            clk_sys = 1'b0;
	logic                            rst_n;
	hps_link_pkg::host_bus_t         host;
	logic [hps_link_pkg::WORD_W-1:0] dout;
	logic                            host_wait;
	hps_link_pkg::joy_t              joystick_0;
	hps_link_pkg::joy_t              joystick_1;
	hps_link_pkg::status_t           status_in;
	logic                            status_set;
	hps_link_pkg::status_t           status;
	hps_link_pkg::ps2_key_t          ps2_key;
	logic                            ioctl_ready;
	logic                            ioctl_valid;
	hps_link_pkg::ioctl_t            ioctl;
	logic                            ioctl_download;

	int seed   = 32'h3537c4d5;
	int checks = 0;
	int errors = 0;
	int cycles = 0;

	// expected core side state carried between tests
	hps_link_pkg::joy_t     joy0_exp;
	hps_link_pkg::joy_t     joy1_exp;
	hps_link_pkg::ps2_key_t key_exp;

	always #10 clk_sys = ~clk_sys;

	hps_link_top hps_link_top_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.host           (host),
		.dout           (dout),
		.host_wait      (host_wait),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.status_in      (status_in),
		.status_set     (status_set),
		.status         (status),
		.ps2_key        (ps2_key),
		.ioctl_ready    (ioctl_ready),
		.ioctl_valid    (ioctl_valid),
		.ioctl          (ioctl),
		.ioctl_download (ioctl_download)
	);

	`include "hps_link_tb_tasks.svh"

	////////////////////////////////////////
	// run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		host        <= '0;
		status_in   <= '0;
		status_set  <= 1'b0;
		ioctl_ready <= 1'b1;
		rst_n       <= 1'b0;
		joy0_exp    = '0;
		joy1_exp    = '0;
		key_exp     = '0;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);

		joystick_frames();
		status_write();
		status_request();
		keyboard_events();
		file_download();

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/hps_link_pkg.sv
source/word_collector.sv
source/host_cmd_ctrl.sv
source/status_exchange.sv
source/ps2_key_decoder.sv
source/file_loader.sv
source/hps_link_top.sv
tb/hps_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the host link testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module hps_link_tb -Mdir obj_dir \
	-o hps_link_sim -f src.f; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/hps_link_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
